/* fir_mac.sv */
`timescale 1ns/1ps
`include "fm_stereo_config.svh"

module fir_mac
    import fm_stereo_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        shift,
    input  sample_t                     sample,
    input  logic                        acc_clear,
    input  logic                        acc_en,
    input  logic [$clog2(`FM_TAPS)-1:0] tap_idx,
    output sample_t                     result
);

    // entry k holds the sample popped k pops ago
    sample_t delay [0:`FM_TAPS-1];
    acc_t    acc;
    acc_t    product;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `FM_TAPS; k++) begin
                delay[k] <= '0;
            end
        end else if (shift) begin
            delay[0] <= sample;
            for (int k = 1; k < `FM_TAPS; k++) begin
                delay[k] <= delay[k-1];
            end
        end
    end

    // both operands widened first so the product keeps its sign
    assign product = acc_t'(FIR_COEFFS[tap_idx]) * acc_t'(delay[tap_idx]);

    always_ff @(posedge clock) begin
        if (acc_clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + product;
        end
    end

    // back to sample scale, upper bits dropped
    assign result = sample_t'(acc >>> `FM_QUANT_BITS);

endmodule

/* fir_sequencer.sv */
`timescale 1ns/1ps
`include "fm_stereo_config.svh"

module fir_sequencer
    import fm_stereo_pkg::*;
(
    input  logic clock,
    input  logic rst_n,
    input  logic lpr_empty,
    input  logic lmr_empty,
    input  logic out_full,
    input  logic phase_last,
    input  logic tap_last,
    output logic pop,
    output logic mac_run,
    output logic acc_clear,
    output logic acc_en,
    output logic emit
);

    fir_state_t state;
    fir_state_t state_next;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= FIR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FIR_IDLE: state_next = FIR_LOAD;
            FIR_LOAD: begin
                // wait for a full pair, run the filter only every FM_DECIM pops
                if (pop) begin
                    state_next = phase_last ? FIR_MAC : FIR_IDLE;
                end
            end
            FIR_MAC:  if (tap_last) state_next = FIR_EMIT;
            FIR_EMIT: if (!out_full) state_next = FIR_IDLE;
            default:  state_next = FIR_IDLE;
        endcase
    end

    assign pop       = (state == FIR_LOAD) && !lpr_empty && !lmr_empty;
    // clear lands on the same edge as the shift of the newest sample
    assign acc_clear = pop && phase_last;
    assign mac_run   = (state == FIR_MAC);
    assign acc_en    = (state == FIR_MAC);
    assign emit      = (state == FIR_EMIT) && !out_full;

    // both input fifos are written and popped together
    assert property (@(posedge clock) disable iff (!rst_n) lpr_empty == lmr_empty)
        else $error("input fifos out of step");

    // a mac run covers every tap exactly once
    assert property (@(posedge clock) disable iff (!rst_n)
        $rose(mac_run) |-> mac_run [*`FM_TAPS] ##1 !mac_run)
        else $error("mac run length differs from tap count");

endmodule

/* fir_tap_counter.sv */
`timescale 1ns/1ps
`include "fm_stereo_config.svh"

module fir_tap_counter
    import fm_stereo_pkg::*;
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       pop,
    input  logic                       mac_run,
    output logic                       phase_last,
    output logic [$clog2(`FM_TAPS)-1:0] tap_idx,
    output logic                       tap_last
);

    logic [$clog2(`FM_DECIM)-1:0] phase;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= '0;
            tap_idx <= '0;
        end else begin
            // one phase step per popped input pair
            if (pop) begin
                phase <= (phase == `FM_DECIM - 1) ? '0 : phase + 1'b1;
            end
            // tap index only runs during a mac run
            if (!mac_run || tap_last) begin
                tap_idx <= '0;
            end else begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

    assign phase_last = pop && (phase == `FM_DECIM - 1);
    assign tap_last   = mac_run && (tap_idx == `FM_TAPS - 1);

    // a run only ends once the last tap was reached
    assert property (@(posedge clock) disable iff (!rst_n) $fell(mac_run) |-> $past(tap_last))
        else $error("mac run ended before the last tap");

endmodule

/* fm_stereo_config.svh */
`ifndef FM_STEREO_CONFIG_SVH
`define FM_STEREO_CONFIG_SVH

// sample width on every data path
`define FM_DATA_WIDTH 32

// low-pass FIR length and output rate divider
`define FM_TAPS 8
`define FM_DECIM 4

// fifo depths in words
`define FM_IN_DEPTH 16
`define FM_OUT_DEPTH 4

// coefficients are Q10, so drop 10 bits after accumulation
`define FM_QUANT_BITS 10

`endif

/* fm_stereo_input.txt */
# S lines carry one lpr and lmr input pair in hex
# E lines carry the expected left and right output pair in hex
S 00000001 00001000
S 00000101 00000E00
S 00000201 00000C00
S 00000301 00000A00
E 000007AC FFFFF8FC
S 00000401 00000800
S 00000501 00000600
S 00000601 00000400
S 00000701 00000200
E 00000C81 FFFFFA81
S 00000801 00000000
S 00000901 FFFFFE00
S 00000A01 FFFFFC00
S 00000B01 FFFFFA00
E 00000881 00000681
S 00000C01 FFFFF800
S 00000D01 FFFFF600
S 00000E01 FFFFF400
S 00000F01 FFFFF200
E 00000481 00001281
S 00001001 FFFFF000
S 00001101 FFFFEE00
S 00001201 FFFFEC00
S 00001301 FFFFEA00
E 00000081 00001E81
S 00001401 FFFFE800
S 00001501 FFFFE600
S 00001601 FFFFE400
S 00001701 FFFFE200
E FFFFFC81 00002A81
S 00001801 FFFFE000
S 00001901 FFFFDE00
S 00001A01 FFFFDC00
S 00001B01 FFFFDA00
E FFFFF881 00003681
S 00001C01 FFFFD800
S 00001D01 FFFFD600
S 00001E01 FFFFD400
S 00001F01 FFFFD200
E FFFFF481 00004281

/* fm_stereo_pkg.sv */
`include "fm_stereo_config.svh"

package fm_stereo_pkg;

    // one baseband sample
    typedef logic signed [`FM_DATA_WIDTH-1:0] sample_t;

    // wide enough for a full run of 32x32 products
    typedef logic signed [63:0] acc_t;

    // sequencer states shared by both channels
    typedef enum logic [1:0] {
        FIR_IDLE,
        FIR_LOAD,
        FIR_MAC,
        FIR_EMIT
    } fir_state_t;

    // symmetric low-pass taps, sum is 1024 so dc gain is one in Q10
    localparam logic signed [31:0] FIR_COEFFS [0:`FM_TAPS-1] = '{
        32'sd16, 32'sd64, 32'sd160, 32'sd272,
        32'sd272, 32'sd160, 32'sd64, 32'sd16
    };

endpackage

/* fm_stereo_top.sv */
`timescale 1ns/1ps
`include "fm_stereo_config.svh"

module fm_stereo_top
    import fm_stereo_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    input  sample_t lpr_din,
    input  sample_t lmr_din,
    input  logic    in_wr_en,
    output logic    in_full,
    input  logic    out_rd_en,
    output logic    out_empty,
    output sample_t left_out,
    output sample_t right_out
);

    logic lpr_full, lmr_full, lpr_empty, lmr_empty;
    logic left_full, right_full, left_empty, right_empty;
    logic out_full;
    logic pop, mac_run, acc_clear, acc_en, emit, phase_last, tap_last;
    logic [$clog2(`FM_TAPS)-1:0] tap_idx;
    sample_t lpr_head, lmr_head, lpr_result, lmr_result, left_din, right_din;
    logic out_wr_en;

    assign in_full   = lpr_full | lmr_full;
    assign out_empty = left_empty | right_empty;
    assign out_full  = left_full | right_full;

    // input side, written together by the host
    sample_fifo #(.DEPTH(`FM_IN_DEPTH)) lpr_in_fifo (
        .clock(clock), .rst_n(rst_n), .wr_en(in_wr_en), .din(lpr_din), .full(lpr_full),
        .rd_en(pop), .dout(lpr_head), .empty(lpr_empty)
    );
    sample_fifo #(.DEPTH(`FM_IN_DEPTH)) lmr_in_fifo (
        .clock(clock), .rst_n(rst_n), .wr_en(in_wr_en), .din(lmr_din), .full(lmr_full),
        .rd_en(pop), .dout(lmr_head), .empty(lmr_empty)
    );

    // one control path steers both filters in lockstep
    fir_sequencer sequencer (
        .clock(clock), .rst_n(rst_n), .lpr_empty(lpr_empty), .lmr_empty(lmr_empty),
        .out_full(out_full), .phase_last(phase_last), .tap_last(tap_last), .pop(pop),
        .mac_run(mac_run), .acc_clear(acc_clear), .acc_en(acc_en), .emit(emit)
    );
    fir_tap_counter tap_counter (
        .clock(clock), .rst_n(rst_n), .pop(pop), .mac_run(mac_run),
        .phase_last(phase_last), .tap_idx(tap_idx), .tap_last(tap_last)
    );

    fir_mac lpr_fir (
        .clock(clock), .rst_n(rst_n), .shift(pop), .sample(lpr_head), .acc_clear(acc_clear),
        .acc_en(acc_en), .tap_idx(tap_idx), .result(lpr_result)
    );
    fir_mac lmr_fir (
        .clock(clock), .rst_n(rst_n), .shift(pop), .sample(lmr_head), .acc_clear(acc_clear),
        .acc_en(acc_en), .tap_idx(tap_idx), .result(lmr_result)
    );

    stereo_matrix matrix (
        .clock(clock), .rst_n(rst_n), .emit(emit), .lpr(lpr_result), .lmr(lmr_result),
        .left(left_din), .right(right_din), .wr_en(out_wr_en)
    );

    // output side, drained together by the host
    sample_fifo #(.DEPTH(`FM_OUT_DEPTH)) left_out_fifo (
        .clock(clock), .rst_n(rst_n), .wr_en(out_wr_en), .din(left_din), .full(left_full),
        .rd_en(out_rd_en), .dout(left_out), .empty(left_empty)
    );
    sample_fifo #(.DEPTH(`FM_OUT_DEPTH)) right_out_fifo (
        .clock(clock), .rst_n(rst_n), .wr_en(out_wr_en), .din(right_din), .full(right_full),
        .rd_en(out_rd_en), .dout(right_out), .empty(right_empty)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f verilog.f --top-module tb_fm_stereo -o sim_fm_stereo
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_fm_stereo
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0

/* sample_fifo.sv */
`timescale 1ns/1ps
`include "fm_stereo_config.svh"

module sample_fifo #(
    parameter int DEPTH = `FM_IN_DEPTH
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  logic [`FM_DATA_WIDTH-1:0] din,
    output logic                      full,
    input  logic                      rd_en,
    output logic [`FM_DATA_WIDTH-1:0] dout,
    output logic                      empty
);

    logic [`FM_DATA_WIDTH-1:0] mem [0:DEPTH-1];
    logic [$clog2(DEPTH)-1:0]  wr_ptr;
    logic [$clog2(DEPTH)-1:0]  rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    // storage, no reset needed
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // show-ahead: head entry is always visible
    assign dout  = mem[rd_ptr];
    assign full  = (count == DEPTH);
    assign empty = (count == 0);

    // producer and consumer must respect the flags
    assert property (@(posedge clock) disable iff (!rst_n) !(wr_en && full) && !(rd_en && empty))
        else $error("sample_fifo overflow or underflow");

endmodule

/* stereo_matrix.sv */
`timescale 1ns/1ps
`include "fm_stereo_config.svh"

module stereo_matrix
    import fm_stereo_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    input  logic    emit,
    input  sample_t lpr,
    input  sample_t lmr,
    output sample_t left,
    output sample_t right,
    output logic    wr_en
);

    // 2L and 2R, wrapping on overflow
    always_ff @(posedge clock) begin
        if (emit) begin
            left  <= lpr + lmr;
            right <= lpr - lmr;
        end
    end

    // write strobe follows emit by one cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= emit;
        end
    end

endmodule

/* tb_fm_stereo.sv */
`timescale 1ns/1ps
`include "fm_stereo_config.svh"

module tb_fm_stereo
    import fm_stereo_pkg::*;
();

    localparam int TIMEOUT = 1000;
    localparam int N_IN = 32;
    localparam int N_OUT = N_IN / `FM_DECIM;

    logic        clock, rst_n, in_wr_en, out_rd_en, in_full, out_empty;
    sample_t     lpr_din, lmr_din, left_out, right_out;
    sample_t     stim_lpr[$], stim_lmr[$], exp_left[$], exp_right[$];
    int          writes = 0;
    logic        full_seen = 1'b0;
    logic [31:0] lfsr;

    fm_stereo_top dut0 (
        .clock(clock), .rst_n(rst_n), .lpr_din(lpr_din), .lmr_din(lmr_din),
        .in_wr_en(in_wr_en), .in_full(in_full), .out_rd_en(out_rd_en),
        .out_empty(out_empty), .left_out(left_out), .right_out(right_out)
    );

    always #5 clock = ~clock;

    // pairs the dut actually accepted, and whether the input side ever filled
    always @(posedge clock) begin
        if (rst_n && in_full && writes < N_IN) begin
            full_seen = 1'b1;
        end
        if (rst_n && in_wr_en && !in_full) begin
            writes = writes + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic load_records();
        int         fd;
        string      line;
        logic [7:0] tag;
        sample_t    a, b;
        fd = $fopen("fm_stereo_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open fm_stereo_input.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;
            end
            void'($sscanf(line, "%c %h %h", tag, a, b));
            if (tag == "S") begin
                stim_lpr.push_back(a);
                stim_lmr.push_back(b);
            end else if (tag == "E") begin
                exp_left.push_back(a);
                exp_right.push_back(b);
            end
        end
        $fclose(fd);
        assert (stim_lpr.size() == N_IN && exp_left.size() == N_OUT)
            else abort_run("data file holds the wrong number of records");
    endtask

    task automatic write_inputs();
        int wait_cnt;
        for (int i = 0; i < N_IN; i++) begin
            wait_cnt = 0;
            while (in_full) begin
                in_wr_en = 1'b0;
                @(negedge clock);
                wait_cnt++;
                assert (wait_cnt < TIMEOUT) else abort_run("in_full never dropped");
            end
            in_wr_en = 1'b1;
            lpr_din  = stim_lpr[i];
            lmr_din  = stim_lmr[i];
            @(negedge clock);
        end
        in_wr_en = 1'b0;
    endtask

    task automatic drain_outputs();
        int got, wait_cnt;
        got = 0;
        wait_cnt = 0;
        // first pair needs a whole decimation group of inputs
        while (out_empty) begin
            @(negedge clock);
            wait_cnt++;
            assert (wait_cnt < TIMEOUT) else abort_run("no output pair ever appeared");
        end
        assert (writes >= `FM_DECIM) else abort_run("output appeared before a full input group");
        // output fifo holds four pairs, so the sequencer stalls in emit meanwhile
        wait_cnt = 0;
        while (writes < N_IN) begin
            @(negedge clock);
            wait_cnt++;
            assert (wait_cnt < TIMEOUT) else abort_run("input writes stalled");
        end
        // the host writes faster than the filter pops
        assert (full_seen) else abort_run("in_full never rose while inputs were pending");
        repeat (100) @(negedge clock);
        wait_cnt = 0;
        while (got < N_OUT) begin
            lfsr = lfsr_step(lfsr);
            out_rd_en = 1'b0;
            if (lfsr[0] && !out_empty) begin
                assert (left_out == exp_left[got]) else abort_run($sformatf(
                    "MISMATCH left_out got %h expected %h", left_out, exp_left[got]));
                assert (right_out == exp_right[got]) else abort_run($sformatf(
                    "MISMATCH right_out got %h expected %h", right_out, exp_right[got]));
                out_rd_en = 1'b1;
                got++;
                wait_cnt = 0;
            end
            wait_cnt++;
            assert (wait_cnt < TIMEOUT) else abort_run("timed out draining output pairs");
            @(negedge clock);
        end
        out_rd_en = 1'b0;
        for (int i = 0; i < 200; i++) begin
            assert (out_empty) else abort_run("an extra output pair appeared");
            @(negedge clock);
        end
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        in_wr_en = 1'b0;
        out_rd_en = 1'b0;
        lpr_din = '0;
        lmr_din = '0;
        lfsr = 32'hf650;
        load_records();
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        assert (out_empty && !in_full) else abort_run("fifo flags wrong after reset");
        fork
            write_inputs();
            drain_outputs();
        join
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
fm_stereo_pkg.sv
sample_fifo.sv
fir_tap_counter.sv
fir_sequencer.sv
fir_mac.sv
stereo_matrix.sv
fm_stereo_top.sv
tb_fm_stereo.sv
